//--- src/conv_geom_pkg.sv
package conv_geom_pkg;

    // element and memory word sizes
    localparam int BYTE_W     = 8;
    localparam int READ_BYTES = 8;
    localparam int READ_W     = READ_BYTES * BYTE_W;

    // MAC array capacity per beat
    localparam int MAX_MACS   = 64;
    localparam int MAX_GROUPS = 8;

    // weight buffer holds the whole kernel set
    localparam int WBUF_BYTES = 512;

    // configuration and address field widths
    localparam int DIM_W       = 8;
    localparam int ADDR_W      = 16;
    localparam int MAC_CNT_W   = $clog2(MAX_MACS + 1);
    localparam int GROUP_CNT_W = $clog2(MAX_GROUPS + 1);

    typedef logic [DIM_W-1:0]       dim_t;
    typedef logic [ADDR_W-1:0]      addr_t;
    typedef logic [MAC_CNT_W-1:0]   mac_cnt_t;
    typedef logic [GROUP_CNT_W-1:0] group_cnt_t;

    // operand bus, byte b sits at bits [b*BYTE_W +: BYTE_W]
    typedef logic [MAX_MACS*BYTE_W-1:0] mac_bus_t;

    // group g uses field g
    typedef logic [MAX_GROUPS*MAC_CNT_W-1:0] group_macs_t;

    // byte j of a read is the byte at addr+j
    typedef logic [READ_W-1:0] read_word_t;

endpackage

//--- src/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

    // scheduler FSM
    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,
        ST_LOAD_WEIGHTS = 3'd1,
        ST_FETCH_PATCH  = 3'd2,
        ST_EMIT         = 3'd3,
        ST_ADVANCE      = 3'd4
    } conv_state_t;

    // upper bound on the group search loop, one pass per possible group
    localparam int GROUP_SEARCH_ITERS = 8;

endpackage

//--- src/weight_loader.sv
`timescale 1ns/1ps

module weight_loader import conv_geom_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load_start_i,
    input  dim_t                         ker_row_i,
    input  dim_t                         ker_col_i,
    input  dim_t                         in_channel_i,
    input  dim_t                         output_channel_i,
    input  read_word_t                   weight_rdata_i,
    output logic                         weight_rd_o,
    output addr_t                        weight_addr_o,
    output logic [WBUF_BYTES*BYTE_W-1:0] wbuf_o,
    output logic                         load_done_o
);

    addr_t total_macs;
    addr_t total_bytes;
    addr_t wr_ptr;
    logic  wr_valid;
    logic  wr_last;

    assign total_macs  = addr_t'(ker_row_i) * addr_t'(ker_col_i) * addr_t'(in_channel_i);
    assign total_bytes = total_macs * addr_t'(output_channel_i);

    // read side, one word per cycle from address 0
    always_ff @(posedge clk) begin
        if (!rst) begin
            weight_rd_o   <= 1'b0;
            weight_addr_o <= '0;
            wr_valid      <= 1'b0;
        end else begin
            wr_valid <= weight_rd_o;
            if (load_start_i) begin
                weight_rd_o   <= 1'b1;
                weight_addr_o <= '0;
            end else if (weight_rd_o) begin
                if (weight_addr_o + addr_t'(READ_BYTES) >= total_bytes) begin
                    weight_rd_o <= 1'b0;
                end else begin
                    weight_addr_o <= weight_addr_o + addr_t'(READ_BYTES);
                end
            end
        end
    end

    // write pointer trails the read address by the memory latency
    always_ff @(posedge clk) begin
        wr_ptr <= weight_addr_o;
    end

    assign wr_last     = (wr_ptr + addr_t'(READ_BYTES)) >= total_bytes;
    assign load_done_o = wr_valid && wr_last;

    // last word may run past the kernel set, keep only the valid bytes
    always_ff @(posedge clk) begin
        addr_t idx;
        if (wr_valid) begin
            for (int j = 0; j < READ_BYTES; j++) begin
                idx = wr_ptr + addr_t'(j);
                if (idx < total_bytes && idx < addr_t'(WBUF_BYTES)) begin
                    wbuf_o[idx*BYTE_W +: BYTE_W] <= weight_rdata_i[j*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

//--- src/patch_fetcher.sv
`timescale 1ns/1ps

module patch_fetcher import conv_geom_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       fetch_start_i,
    input  dim_t       conv_row_i,
    input  dim_t       conv_col_i,
    input  dim_t       img_row_i,
    input  dim_t       ker_row_i,
    input  dim_t       ker_col_i,
    input  dim_t       in_channel_i,
    input  read_word_t data_rdata_i,
    output logic       data_rd_o,
    output addr_t      data_addr_o,
    output mac_bus_t   patch_o,
    output logic       fetch_done_o
);

    addr_t col_bytes;
    dim_t  kc;
    addr_t off;
    logic  wr_valid;
    dim_t  wr_kc;
    addr_t wr_off;
    logic  wr_last;
    logic  col_end;

    // one kernel column is ker_row*in_channel contiguous image bytes
    assign col_bytes = addr_t'(ker_row_i) * addr_t'(in_channel_i);
    assign col_end   = (off + addr_t'(READ_BYTES)) >= col_bytes;

    assign data_addr_o = ((addr_t'(conv_col_i) + addr_t'(kc)) * addr_t'(img_row_i)
                         + addr_t'(conv_row_i)) * addr_t'(in_channel_i) + off;

    always_ff @(posedge clk) begin
        if (!rst) begin
            data_rd_o    <= 1'b0;
            kc           <= '0;
            off          <= '0;
            wr_valid     <= 1'b0;
            fetch_done_o <= 1'b0;
        end else begin
            wr_valid     <= data_rd_o;
            fetch_done_o <= wr_valid && wr_last;
            if (fetch_start_i) begin
                data_rd_o <= 1'b1;
                kc        <= '0;
                off       <= '0;
            end else if (data_rd_o) begin
                if (col_end) begin
                    off <= '0;
                    if (kc == ker_col_i - dim_t'(1)) begin
                        data_rd_o <= 1'b0;
                    end else begin
                        kc <= kc + dim_t'(1);
                    end
                end else begin
                    off <= off + addr_t'(READ_BYTES);
                end
            end
        end
    end

    // delayed copy for the returning data
    always_ff @(posedge clk) begin
        wr_kc  <= kc;
        wr_off <= off;
    end

    assign wr_last = (wr_off + addr_t'(READ_BYTES)) >= col_bytes
                     && wr_kc == ker_col_i - dim_t'(1);

    always_ff @(posedge clk) begin
        addr_t idx;
        if (fetch_start_i) begin
            patch_o <= '0;
        end else if (wr_valid) begin
            for (int j = 0; j < READ_BYTES; j++) begin
                idx = addr_t'(wr_kc) * col_bytes + wr_off + addr_t'(j);
                // partial read at the column end
                if (wr_off + addr_t'(j) < col_bytes && idx < addr_t'(MAX_MACS)) begin
                    patch_o[idx*BYTE_W +: BYTE_W] <= data_rdata_i[j*BYTE_W +: BYTE_W];
                end
            end
        end
    end

endmodule

//--- src/conv_scheduler.sv
`timescale 1ns/1ps

module conv_scheduler import conv_geom_pkg::*, conv_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  dim_t       img_row_i,
    input  dim_t       img_col_i,
    input  dim_t       ker_row_i,
    input  dim_t       ker_col_i,
    input  dim_t       in_channel_i,
    input  dim_t       output_channel_i,
    input  dim_t       stride_row_i,
    input  dim_t       stride_col_i,
    input  logic       load_done_i,
    input  logic       fetch_done_i,
    output logic       load_start_o,
    output logic       fetch_start_o,
    output dim_t       conv_row_o,
    output dim_t       conv_col_o,
    output logic       emit_o,
    output dim_t       oc_base_o,
    output group_cnt_t beat_groups_o,
    output logic       busy_o,
    output logic       done_o
);

    conv_state_t      state;
    conv_state_t      state_nxt;
    addr_t            total_macs;
    group_cnt_t       num_groups;
    dim_t             oc_left;
    logic             start_ok;
    logic             row_adv;
    logic             col_adv;
    logic             last_pos;
    logic             last_beat;

    assign total_macs = addr_t'(ker_row_i) * addr_t'(ker_col_i) * addr_t'(in_channel_i);

    // groups that fit in the MAC array, by repeated subtraction
    always_comb begin
        addr_t remaining;
        remaining  = addr_t'(MAX_MACS);
        num_groups = '0;
        for (int i = 0; i < GROUP_SEARCH_ITERS; i++) begin
            if (remaining >= total_macs && total_macs != '0) begin
                num_groups = num_groups + group_cnt_t'(1);
                remaining  = remaining - total_macs;
            end
        end
    end

    // final beat of a position may carry fewer groups
    assign oc_left       = output_channel_i - oc_base_o;
    assign beat_groups_o = (oc_left < dim_t'(num_groups)) ? group_cnt_t'(oc_left) : num_groups;
    assign last_beat     = (oc_base_o + dim_t'(beat_groups_o)) >= output_channel_i;

    // VALID padding, row steps inside the column
    assign row_adv  = ({2'b00, conv_row_o} + {2'b00, stride_row_i} + {2'b00, ker_row_i})
                      <= {2'b00, img_row_i};
    assign col_adv  = ({2'b00, conv_col_o} + {2'b00, stride_col_i} + {2'b00, ker_col_i})
                      <= {2'b00, img_col_i};
    assign last_pos = !row_adv && !col_adv;

    assign start_ok      = state == ST_IDLE && start_i && !busy_o;
    assign load_start_o  = start_ok;
    assign fetch_start_o = (state == ST_LOAD_WEIGHTS && load_done_i) || state == ST_ADVANCE;
    assign emit_o        = state == ST_EMIT;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:         if (start_ok) state_nxt = ST_LOAD_WEIGHTS;
            ST_LOAD_WEIGHTS: if (load_done_i) state_nxt = ST_FETCH_PATCH;
            ST_FETCH_PATCH:  if (fetch_done_i) state_nxt = ST_EMIT;
            ST_EMIT: begin
                if (last_beat) begin
                    state_nxt = last_pos ? ST_IDLE : ST_ADVANCE;
                end
            end
            ST_ADVANCE:      state_nxt = ST_FETCH_PATCH;
            default:         state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= ST_IDLE;
            conv_row_o <= '0;
            conv_col_o <= '0;
            oc_base_o  <= '0;
            busy_o     <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_o <= state == ST_EMIT && last_beat && last_pos;
            // busy covers the last ready beat, drops after done
            if (start_ok) begin
                busy_o     <= 1'b1;
                conv_row_o <= '0;
                conv_col_o <= '0;
            end else if (done_o) begin
                busy_o <= 1'b0;
            end
            if (state == ST_FETCH_PATCH && fetch_done_i) begin
                oc_base_o <= '0;
            end else if (state == ST_EMIT) begin
                oc_base_o <= oc_base_o + dim_t'(num_groups);
            end
            if (state == ST_ADVANCE) begin
                if (row_adv) begin
                    conv_row_o <= conv_row_o + stride_row_i;
                end else begin
                    conv_row_o <= '0;
                    conv_col_o <= conv_col_o + stride_col_i;
                end
            end
        end
    end

endmodule

//--- src/mac_operand_packer.sv
`timescale 1ns/1ps

module mac_operand_packer import conv_geom_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         emit_i,
    input  dim_t                         oc_base_i,
    input  group_cnt_t                   beat_groups_i,
    input  dim_t                         ker_row_i,
    input  dim_t                         ker_col_i,
    input  dim_t                         in_channel_i,
    input  mac_bus_t                     patch_i,
    input  logic [WBUF_BYTES*BYTE_W-1:0] wbuf_i,
    output logic                         mac_data_ready_o,
    output mac_bus_t                     data_mac_o,
    output mac_bus_t                     weight_mac_o,
    output group_cnt_t                   num_groups_o,
    output group_macs_t                  num_macs_o
);

    addr_t       tm_full;
    mac_cnt_t    total_macs;
    mac_bus_t    data_nxt;
    mac_bus_t    weight_nxt;
    group_macs_t macs_nxt;

    assign tm_full    = addr_t'(ker_row_i) * addr_t'(ker_col_i) * addr_t'(in_channel_i);
    assign total_macs = mac_cnt_t'(tm_full);

    always_comb begin
        int used;
        int win_base;
        used       = int'(beat_groups_i) * int'(total_macs);
        win_base   = int'(oc_base_i) * int'(total_macs);
        data_nxt   = '0;
        weight_nxt = '0;
        macs_nxt   = '0;
        // patch copy per group slot
        for (int g = 0; g < MAX_GROUPS; g++) begin
            if (g < int'(beat_groups_i)) begin
                macs_nxt[g*MAC_CNT_W +: MAC_CNT_W] = total_macs;
                for (int b = 0; b < MAX_MACS; b++) begin
                    if (b < int'(total_macs) && g * int'(total_macs) + b < MAX_MACS) begin
                        data_nxt[(g*int'(total_macs)+b)*BYTE_W +: BYTE_W] =
                            patch_i[b*BYTE_W +: BYTE_W];
                    end
                end
            end
        end
        // weights of consecutive output channels from oc_base
        for (int p = 0; p < MAX_MACS; p++) begin
            if (p < used && win_base + p < WBUF_BYTES) begin
                weight_nxt[p*BYTE_W +: BYTE_W] = wbuf_i[(win_base+p)*BYTE_W +: BYTE_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            mac_data_ready_o <= 1'b0;
            data_mac_o       <= '0;
            weight_mac_o     <= '0;
            num_groups_o     <= '0;
            num_macs_o       <= '0;
        end else begin
            mac_data_ready_o <= emit_i;
            if (emit_i) begin
                data_mac_o   <= data_nxt;
                weight_mac_o <= weight_nxt;
                num_groups_o <= beat_groups_i;
                num_macs_o   <= macs_nxt;
            end
        end
    end

endmodule

//--- src/conv_operand_seq.sv
`timescale 1ns/1ps

module conv_operand_seq import conv_geom_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  dim_t        img_row_i,
    input  dim_t        img_col_i,
    input  dim_t        ker_row_i,
    input  dim_t        ker_col_i,
    input  dim_t        in_channel_i,
    input  dim_t        output_channel_i,
    input  dim_t        stride_row_i,
    input  dim_t        stride_col_i,
    input  read_word_t  data_rdata_i,
    input  read_word_t  weight_rdata_i,
    output logic        data_rd_o,
    output logic        weight_rd_o,
    output addr_t       data_addr_o,
    output addr_t       weight_addr_o,
    output logic        mac_data_ready_o,
    output mac_bus_t    data_mac_o,
    output mac_bus_t    weight_mac_o,
    output group_cnt_t  num_groups_o,
    output group_macs_t num_macs_o,
    output logic        busy_o,
    output logic        done_o
);

    logic                        load_start;
    logic                        load_done;
    logic                        fetch_start;
    logic                        fetch_done;
    logic                        emit;
    dim_t                        conv_row;
    dim_t                        conv_col;
    dim_t                        oc_base;
    group_cnt_t                  beat_groups;
    logic [WBUF_BYTES*BYTE_W-1:0] wbuf;
    mac_bus_t                    patch;

    weight_loader weight_loader_inst (
        .clk              (clk),
        .rst              (rst),
        .load_start_i     (load_start),
        .ker_row_i        (ker_row_i),
        .ker_col_i        (ker_col_i),
        .in_channel_i     (in_channel_i),
        .output_channel_i (output_channel_i),
        .weight_rdata_i   (weight_rdata_i),
        .weight_rd_o      (weight_rd_o),
        .weight_addr_o    (weight_addr_o),
        .wbuf_o           (wbuf),
        .load_done_o      (load_done)
    );

    patch_fetcher patch_fetcher_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_start_i (fetch_start),
        .conv_row_i    (conv_row),
        .conv_col_i    (conv_col),
        .img_row_i     (img_row_i),
        .ker_row_i     (ker_row_i),
        .ker_col_i     (ker_col_i),
        .in_channel_i  (in_channel_i),
        .data_rdata_i  (data_rdata_i),
        .data_rd_o     (data_rd_o),
        .data_addr_o   (data_addr_o),
        .patch_o       (patch),
        .fetch_done_o  (fetch_done)
    );

    conv_scheduler conv_scheduler_inst (
        .clk              (clk),
        .rst              (rst),
        .start_i          (start_i),
        .img_row_i        (img_row_i),
        .img_col_i        (img_col_i),
        .ker_row_i        (ker_row_i),
        .ker_col_i        (ker_col_i),
        .in_channel_i     (in_channel_i),
        .output_channel_i (output_channel_i),
        .stride_row_i     (stride_row_i),
        .stride_col_i     (stride_col_i),
        .load_done_i      (load_done),
        .fetch_done_i     (fetch_done),
        .load_start_o     (load_start),
        .fetch_start_o    (fetch_start),
        .conv_row_o       (conv_row),
        .conv_col_o       (conv_col),
        .emit_o           (emit),
        .oc_base_o        (oc_base),
        .beat_groups_o    (beat_groups),
        .busy_o           (busy_o),
        .done_o           (done_o)
    );

    mac_operand_packer mac_operand_packer_inst (
        .clk              (clk),
        .rst              (rst),
        .emit_i           (emit),
        .oc_base_i        (oc_base),
        .beat_groups_i    (beat_groups),
        .ker_row_i        (ker_row_i),
        .ker_col_i        (ker_col_i),
        .in_channel_i     (in_channel_i),
        .patch_i          (patch),
        .wbuf_i           (wbuf),
        .mac_data_ready_o (mac_data_ready_o),
        .data_mac_o       (data_mac_o),
        .weight_mac_o     (weight_mac_o),
        .num_groups_o     (num_groups_o),
        .num_macs_o       (num_macs_o)
    );

endmodule

//--- tests/conv_operand_seq_checker.sv
`timescale 1ns/1ps

module conv_operand_seq_checker (
    input logic clk,
    input logic rst,
    input logic ready_i,
    input logic busy_i,
    input logic done_i,
    input logic data_rd_i,
    input logic weight_rd_i
);

    // end of run is a single pulse, busy drops right after it
    done_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_i |=> !done_i && !busy_i)
        else $error("done_o longer than one cycle or busy_o still high after it");

    // a MAC beat never overlaps the reads of a patch fetch or a weight load
    ready_without_reads: assert property (@(posedge clk) disable iff (!rst)
        ready_i |-> !data_rd_i && !weight_rd_i)
        else $error("mac_data_ready_o during a memory read");

    ready_while_busy: assert property (@(posedge clk) disable iff (!rst)
        ready_i |-> busy_i)
        else $error("mac_data_ready_o while not busy");

    // memory traffic only during a run
    reads_while_busy: assert property (@(posedge clk) disable iff (!rst)
        (data_rd_i || weight_rd_i) |-> busy_i)
        else $error("memory read while not busy");

    ready_low_in_reset: assert property (@(posedge clk)
        !rst |=> !ready_i)
        else $error("mac_data_ready_o high after reset");

endmodule

//--- tests/conv_operand_seq_tb.sv
`timescale 1ns/1ps

module conv_operand_seq_tb
    import conv_geom_pkg::*, conv_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RUNS     = 8;
    localparam int MAX_OC       = 16;
    localparam int SEED         = 32'h4a92_e658;
    // worst case run: full weight load, 6x6 positions, every output channel in its own beat
    localparam int LOAD_CYCLES     = WBUF_BYTES / READ_BYTES + 6;
    localparam int POS_CYCLES      = MAX_MACS / READ_BYTES + 4 + MAX_OC + 6;
    localparam int RUN_CYCLES      = LOAD_CYCLES + 36 * POS_CYCLES + 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 + NUM_RUNS * RUN_CYCLES;

    logic        clk;
    logic        rst;
    logic        start;
    dim_t        img_row;
    dim_t        img_col;
    dim_t        ker_row;
    dim_t        ker_col;
    dim_t        in_channel;
    dim_t        output_channel;
    dim_t        stride_row;
    dim_t        stride_col;
    read_word_t  data_rdata = '0;
    read_word_t  weight_rdata = '0;
    logic        data_rd;
    logic        weight_rd;
    addr_t       data_addr;
    addr_t       weight_addr;
    logic        mac_ready;
    mac_bus_t    data_mac;
    mac_bus_t    weight_mac;
    group_cnt_t  num_groups;
    group_macs_t num_macs;
    logic        busy;
    logic        done;

    logic [7:0] data_mem [0:65535];
    logic [7:0] weight_mem [0:1023];
    logic       data_pend = 1'b0;
    logic       weight_pend = 1'b0;
    addr_t      data_pend_addr = '0;
    addr_t      weight_pend_addr = '0;

    // model state of the current run
    int tm;
    int ng;
    int q_row[$];
    int q_col[$];
    int q_oc[$];

    conv_operand_seq conv_operand_seq_inst (
        .clk              (clk),
        .rst              (rst),
        .start_i          (start),
        .img_row_i        (img_row),
        .img_col_i        (img_col),
        .ker_row_i        (ker_row),
        .ker_col_i        (ker_col),
        .in_channel_i     (in_channel),
        .output_channel_i (output_channel),
        .stride_row_i     (stride_row),
        .stride_col_i     (stride_col),
        .data_rdata_i     (data_rdata),
        .weight_rdata_i   (weight_rdata),
        .data_rd_o        (data_rd),
        .weight_rd_o      (weight_rd),
        .data_addr_o      (data_addr),
        .weight_addr_o    (weight_addr),
        .mac_data_ready_o (mac_ready),
        .data_mac_o       (data_mac),
        .weight_mac_o     (weight_mac),
        .num_groups_o     (num_groups),
        .num_macs_o       (num_macs),
        .busy_o           (busy),
        .done_o           (done)
    );

    bind conv_operand_seq conv_operand_seq_checker checker_inst (
        .clk         (clk),
        .rst         (rst),
        .ready_i     (mac_data_ready_o),
        .busy_i      (busy_o),
        .done_i      (done_o),
        .data_rd_i   (data_rd_o),
        .weight_rd_i (weight_rd_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memories answer one cycle after the read, byte j from addr+j
    always @(negedge clk) begin
        for (int j = 0; j < READ_BYTES; j++) begin
            if (data_pend) begin
                data_rdata[j*BYTE_W +: BYTE_W] <= data_mem[data_pend_addr + addr_t'(j)];
            end
            if (weight_pend) begin
                weight_rdata[j*BYTE_W +: BYTE_W] <=
                    weight_mem[(weight_pend_addr + addr_t'(j)) & 16'h03ff];
            end
        end
        data_pend        <= data_rd;
        data_pend_addr   <= data_addr;
        weight_pend      <= weight_rd;
        weight_pend_addr <= weight_addr;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_mac_bus(input string name, input mac_bus_t got, input mac_bus_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_groups(input string name, input group_cnt_t got,
                                  input group_cnt_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_macs(input string name, input group_macs_t got,
                                input group_macs_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    task automatic compare_state(input string name, input conv_state_t got,
                                 input conv_state_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch at %0t: %s got %0d expected %0d",
                                     $time, name, got, exp));
        end
    endtask

    // patch index k = kc*ker_row*in_channel + kr*in_channel + ch, copied per group
    function automatic mac_bus_t expect_data(input int row, input int col, input int bg);
        mac_bus_t bus;
        int       col_len;
        int       kc_i;
        int       off;
        bus     = '0;
        col_len = int'(ker_row) * int'(in_channel);
        for (int g = 0; g < bg; g++) begin
            for (int k = 0; k < tm; k++) begin
                kc_i = k / col_len;
                off  = k % col_len;
                bus[(g*tm+k)*BYTE_W +: BYTE_W] =
                    data_mem[((col + kc_i) * int'(img_row) + row) * int'(in_channel) + off];
            end
        end
        return bus;
    endfunction

    function automatic mac_bus_t expect_weights(input int oc_base, input int bg);
        mac_bus_t bus;
        bus = '0;
        for (int p = 0; p < bg * tm; p++) begin
            bus[p*BYTE_W +: BYTE_W] = weight_mem[oc_base * tm + p];
        end
        return bus;
    endfunction

    function automatic group_macs_t expect_macs(input int bg);
        group_macs_t f;
        f = '0;
        for (int g = 0; g < bg; g++) begin
            f[g*MAC_CNT_W +: MAC_CNT_W] = mac_cnt_t'(tm);
        end
        return f;
    endfunction

    task automatic check_idle();
        compare_flag("mac_data_ready_o", mac_ready, 1'b0);
        compare_flag("busy_o", busy, 1'b0);
        compare_flag("done_o", done, 1'b0);
        compare_flag("data_rd_o", data_rd, 1'b0);
        compare_flag("weight_rd_o", weight_rd, 1'b0);
        compare_mac_bus("data_mac_o", data_mac, '0);
        compare_mac_bus("weight_mac_o", weight_mac, '0);
        compare_groups("num_groups_o", num_groups, '0);
        compare_macs("num_macs_o", num_macs, '0);
    endtask

    // run 0 is a 1x1 kernel, run 1 has columns wider than one read
    task automatic pick_config(input int run);
        int kr;
        int kc;
        int ic;
        int oc_max;
        kr = 1 + int'($urandom % 4);
        kc = 1 + int'($urandom % 4);
        ic = 1 + int'($urandom % 8);
        while (kr * kc * ic > MAX_MACS) begin
            ic = 1 + int'($urandom % 8);
        end
        if (run == 0) begin
            kr = 1;
            kc = 1;
            ic = 1;
        end else if (run == 1) begin
            kr = 3;
            kc = 2;
            ic = 5;
        end
        tm     = kr * kc * ic;
        ng     = (MAX_MACS / tm > MAX_GROUPS) ? MAX_GROUPS : MAX_MACS / tm;
        oc_max = (WBUF_BYTES / tm > MAX_OC) ? MAX_OC : WBUF_BYTES / tm;
        ker_row        = dim_t'(kr);
        ker_col        = dim_t'(kc);
        in_channel     = dim_t'(ic);
        output_channel = dim_t'(1 + $urandom % oc_max);
        stride_row     = dim_t'(1 + $urandom % 3);
        stride_col     = dim_t'(1 + $urandom % 3);
        img_row        = dim_t'(kr + $urandom % 6);
        img_col        = dim_t'(kc + $urandom % 6);
        if (run == 0) begin
            output_channel = 8'd11;
        end else if (run == 1) begin
            output_channel = 8'd5;
            stride_row     = 8'd2;
            stride_col     = 8'd2;
            img_row        = dim_t'(kr + 4);
            img_col        = dim_t'(kc + 4);
        end
    endtask

    // VALID padding, row steps inside the column, oc_base steps inside a position
    task automatic build_positions();
        int row;
        int col;
        int ended;
        row   = 0;
        col   = 0;
        ended = 0;
        while (!ended) begin
            for (int oc = 0; oc < int'(output_channel); oc += ng) begin
                q_row.push_back(row);
                q_col.push_back(col);
                q_oc.push_back(oc);
            end
            if (row + int'(stride_row) + int'(ker_row) <= int'(img_row)) begin
                row += int'(stride_row);
            end else if (col + int'(stride_col) + int'(ker_col) <= int'(img_col)) begin
                row = 0;
                col += int'(stride_col);
            end else begin
                ended = 1;
            end
        end
    endtask

    task automatic run_and_check();
        int row;
        int col;
        int oc_base;
        int bg;
        int ended;
        ended = 0;
        build_positions();
        $display("run: kernel %0dx%0dx%0d, %0d output channels, %0d beats",
                 ker_row, ker_col, in_channel, output_channel, q_oc.size());
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_flag("busy_o", busy, 1'b1);
        while (!ended) begin
            @(negedge clk);
            if (mac_ready) begin
                if (q_oc.size() == 0) begin
                    report_failure("extra MAC beat after the expected beat list");
                end
                row     = q_row.pop_front();
                col     = q_col.pop_front();
                oc_base = q_oc.pop_front();
                bg      = (int'(output_channel) - oc_base < ng)
                          ? int'(output_channel) - oc_base : ng;
                compare_mac_bus("data_mac_o", data_mac, expect_data(row, col, bg));
                compare_mac_bus("weight_mac_o", weight_mac, expect_weights(oc_base, bg));
                compare_groups("num_groups_o", num_groups, group_cnt_t'(bg));
                compare_macs("num_macs_o", num_macs, expect_macs(bg));
            end
            if (done) begin
                if (q_oc.size() != 0) begin
                    report_failure($sformatf("done_o came with %0d beats still missing",
                                             q_oc.size()));
                end
                ended = 1;
            end
        end
        @(negedge clk);
        compare_flag("busy_o", busy, 1'b0);
        compare_flag("done_o", done, 1'b0);
        compare_state("scheduler state", conv_operand_seq_inst.conv_scheduler_inst.state,
                      ST_IDLE);
    endtask

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        report_failure("timeout, the runs did not finish within the cycle limit");
    end

    initial begin
        int seed_state;
        seed_state     = $urandom(SEED);
        rst            = 1'b0;
        start          = 1'b0;
        img_row        = 8'd1;
        img_col        = 8'd1;
        ker_row        = 8'd1;
        ker_col        = 8'd1;
        in_channel     = 8'd1;
        output_channel = 8'd1;
        stride_row     = 8'd1;
        stride_col     = 8'd1;
        for (int i = 0; i < 65536; i++) begin
            data_mem[i] = 8'($urandom);
        end
        for (int i = 0; i < 1024; i++) begin
            weight_mem[i] = 8'($urandom);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        // idle after reset, no start yet
        repeat (3) begin
            @(negedge clk);
            check_idle();
        end
        for (int r = 0; r < NUM_RUNS; r++) begin
            pick_config(r);
            run_and_check();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- conv_operand_seq.f
src/conv_geom_pkg.sv
src/conv_ctrl_pkg.sv
src/weight_loader.sv
src/patch_fetcher.sv
src/conv_scheduler.sv
src/mac_operand_packer.sv
src/conv_operand_seq.sv
tests/conv_operand_seq_checker.sv
tests/conv_operand_seq_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --assert -Wno-fatal --top-module conv_operand_seq_tb \
    -f conv_operand_seq.f -o conv_operand_seq_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/conv_operand_seq_sim > sim.log 2>&1 \
    || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
